/* Makefile */
TOP := tb_dbg_mam

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

# The run only counts as passed when the verdict line is in the log
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
verilog/dbg_mam_pkg.sv
verilog/mam_cmd_if.sv
verilog/mam_req_ctrl.sv
verilog/mam_write_engine.sv
verilog/mam_read_engine.sv
verilog/dbg_mam_top.sv
tests/dbg_mam_chk.sv
tests/tb_dbg_mam.sv

/* tests/dbg_mam_chk.sv */
`default_nettype none

module dbg_mam_chk
  import dbg_mam_pkg::*;
(
  input wire              clk_i,
  input wire              rst_i,
  input wire [ADDR_W-1:0] awaddr_i,
  input wire              awvalid_i,
  input wire              awready_i,
  input wire [DATA_W-1:0] wdata_i,
  input wire              wvalid_i,
  input wire              wready_i,
  input wire [ADDR_W-1:0] araddr_i,
  input wire              arvalid_i,
  input wire              arready_i,
  input wire              done_i,
  input wire              err_i
);

  int unsigned fails = 0;  // Failed assertion count

  ////////////////////
  // AXI4-Lite valid hold

  aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else begin
      $error("AWVALID dropped or AWADDR moved before AWREADY");
      fails++;
    end

  w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else begin
      $error("WVALID dropped or WDATA moved before WREADY");
      fails++;
    end

  ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      $error("ARVALID dropped or ARADDR moved before ARREADY");
      fails++;
    end

  ////////////////////
  // Completion status

  done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
    else begin
      $error("done_o held for more than one cycle");
      fails++;
    end

  err_with_done: assert property (@(posedge clk_i) disable iff (rst_i) err_i |-> done_i)
    else begin
      $error("err_o high without done_o");
      fails++;
    end

endmodule

bind dbg_mam_top dbg_mam_chk dbg_mam_chk_inst (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .awaddr_i  (axi_awaddr_o),
  .awvalid_i (axi_awvalid_o),
  .awready_i (axi_awready_i),
  .wdata_i   (axi_wdata_o),
  .wvalid_i  (axi_wvalid_o),
  .wready_i  (axi_wready_i),
  .araddr_i  (axi_araddr_o),
  .arvalid_i (axi_arvalid_o),
  .arready_i (axi_arready_i),
  .done_i    (done_o),
  .err_i     (err_o)
);

`default_nettype wire

/* tests/tb_dbg_mam.sv */
`default_nettype none

module tb_dbg_mam
  import dbg_mam_pkg::*;
();

  localparam int          CYCLE_LIMIT = 4000;           // Summed worst case of all tests, with margin
  localparam int          MEM_WORDS   = 256;
  localparam logic [3:0]  ERR_NIBBLE  = 4'hF;           // Top nibble of the faulting window
  localparam logic [31:0] SEED        = 32'h7a14_b380;

  logic              clk_i;
  logic              rst_i;
  logic              req_valid_i;
  logic              req_ready_o;
  logic              req_we_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [BEAT_W-1:0] req_beats_i;
  logic              wr_valid_i;
  logic [DATA_W-1:0] wr_data_i;
  logic              wr_ready_o;
  logic              rd_valid_o;
  logic [DATA_W-1:0] rd_data_o;
  logic              rd_ready_i;
  logic              done_o;
  logic              err_o;
  logic [ADDR_W-1:0] axi_awaddr_o;
  logic              axi_awvalid_o;
  logic              axi_awready_i;
  logic [DATA_W-1:0] axi_wdata_o;
  logic [STRB_W-1:0] axi_wstrb_o;
  logic              axi_wvalid_o;
  logic              axi_wready_i;
  logic [1:0]        axi_bresp_i;
  logic              axi_bvalid_i;
  logic              axi_bready_o;
  logic [ADDR_W-1:0] axi_araddr_o;
  logic              axi_arvalid_o;
  logic              axi_arready_i;
  logic [DATA_W-1:0] axi_rdata_i;
  logic [1:0]        axi_rresp_i;
  logic              axi_rvalid_i;
  logic              axi_rready_o;

  logic [DATA_W-1:0] mem [MEM_WORDS];               // Slave storage, word indexed
  logic [DATA_W-1:0] exp_mem [logic [ADDR_W-1:0]];  // Host view, by byte address
  logic [STRB_W-1:0] last_wstrb;                    // Strobes of the latest W beat
  int                slave_seed = SEED;
  int                host_seed  = ~SEED;
  int                errors     = 0;
  int                checks     = 0;
  int                tests_run  = 0;
  int                cycles     = 0;

  dbg_mam_top dbg_mam_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: no verdict after %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Checks

  function automatic logic in_err_range(input logic [ADDR_W-1:0] addr);
    return addr[31:28] == ERR_NIBBLE;
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] got);
    checks++;
    assert (got === exp) else begin
      $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    check_value(name, DATA_W'(exp), DATA_W'(got));
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    $display("test %0d %-16s %s", tests_run, name, (errors == errs_at_start) ? "ok" : "FAILED");
  endtask

  ////////////////////
  // AXI4-Lite slave

  initial begin : axi_slave
    logic [31:0]       rnd;
    logic              aw_got;
    logic              w_got;
    logic              ar_got;
    logic              b_hs;
    logic              r_hs;
    logic [ADDR_W-1:0] aw_addr;
    logic [ADDR_W-1:0] ar_addr;
    logic [DATA_W-1:0] w_data;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[7:0], ~i[7:0], 8'h5A, i[7:0]};  // Every index gives its own word
    end
    aw_got        = 1'b0;
    w_got         = 1'b0;
    ar_got        = 1'b0;
    aw_addr       = '0;
    ar_addr       = '0;
    w_data        = '0;
    last_wstrb    = '0;
    axi_awready_i = 1'b0;
    axi_wready_i  = 1'b0;
    axi_arready_i = 1'b0;
    axi_bvalid_i  = 1'b0;
    axi_bresp_i   = RESP_OKAY;
    axi_rvalid_i  = 1'b0;
    axi_rresp_i   = RESP_OKAY;
    axi_rdata_i   = '0;
    forever begin
      @(negedge clk_i);  // Handshake state is settled here
      if (axi_awvalid_o && axi_awready_i) begin
        aw_got  = 1'b1;
        aw_addr = axi_awaddr_o;
      end
      if (axi_wvalid_o && axi_wready_i) begin
        w_got      = 1'b1;
        w_data     = axi_wdata_o;
        last_wstrb = axi_wstrb_o;
      end
      if (axi_arvalid_o && axi_arready_i) begin
        ar_got  = 1'b1;
        ar_addr = axi_araddr_o;
      end
      b_hs = axi_bvalid_i && axi_bready_o;
      r_hs = axi_rvalid_i && axi_rready_o;
      @(posedge clk_i);
      #1;
      rnd           = $random(slave_seed);
      axi_awready_i = rnd[0];
      axi_wready_i  = rnd[1];
      axi_arready_i = rnd[2];
      if (b_hs) axi_bvalid_i = 1'b0;
      if (r_hs) axi_rvalid_i = 1'b0;
      // Responses may lag a cycle or two
      if (aw_got && w_got && !axi_bvalid_i && rnd[3]) begin
        if (!in_err_range(aw_addr)) mem[aw_addr[9:2]] = w_data;
        axi_bresp_i  = in_err_range(aw_addr) ? RESP_SLVERR : RESP_OKAY;
        axi_bvalid_i = 1'b1;
        aw_got       = 1'b0;
        w_got        = 1'b0;
      end
      if (ar_got && !axi_rvalid_i && rnd[4]) begin
        axi_rdata_i  = in_err_range(ar_addr) ? '0 : mem[ar_addr[9:2]];
        axi_rresp_i  = in_err_range(ar_addr) ? RESP_SLVERR : RESP_OKAY;
        axi_rvalid_i = 1'b1;
        ar_got       = 1'b0;
      end
    end
  end

  ////////////////////
  // Host side

  // Entered and left 1 unit after a rising edge
  task automatic send_req(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [BEAT_W-1:0] beats);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_beats_i = beats;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_done(input logic exp_err);
    do begin
      @(negedge clk_i);
      assert (!rd_valid_o) else begin
        $display("t=%0t read word offered after the last one was taken", $time);
        errors++;
      end
    end while (!done_o);
    check_bit("err_o", exp_err, err_o);
    check_bit("wr_ready_o", 1'b0, wr_ready_o);  // No further host word wanted
    @(posedge clk_i);
    #1;
  endtask

  task automatic do_write(input logic [ADDR_W-1:0] base, input logic [BEAT_W-1:0] beats,
                          input logic stall);
    int                n;
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              hs;
    logic              exp_err;
    n       = (beats == 0) ? 1 : int'(beats);  // Zero runs as one word
    exp_err = 1'b0;
    send_req(1'b1, base, beats);
    for (int k = 0; k < n; k++) begin
      addr = base + WORD_BYTES * k;
      data = $random(host_seed);
      hs   = 1'b0;
      while (!hs) begin
        rnd        = $random(host_seed);
        wr_valid_i = stall ? rnd[0] : 1'b1;
        wr_data_i  = data;
        @(negedge clk_i);
        hs = wr_valid_i && wr_ready_o;
        @(posedge clk_i);
        #1;
      end
      if (in_err_range(addr)) exp_err = 1'b1;
      else exp_mem[addr] = data;
    end
    wr_valid_i = 1'b0;
    wait_done(exp_err);
    check_value("axi_wstrb_o", DATA_W'(4'hF), DATA_W'(last_wstrb));
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] base, input logic [BEAT_W-1:0] beats,
                         input logic stall);
    int                n;
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] held_data;
    logic              held;
    logic              hs;
    logic              exp_err;
    n         = (beats == 0) ? 1 : int'(beats);
    exp_err   = 1'b0;
    held      = 1'b0;
    held_data = '0;
    got       = '0;
    send_req(1'b0, base, beats);
    for (int k = 0; k < n; k++) begin
      addr = base + WORD_BYTES * k;
      exp  = in_err_range(addr) ? '0 : exp_mem[addr];  // Faulting reads give zero
      hs   = 1'b0;
      while (!hs) begin
        rnd        = $random(host_seed);
        rd_ready_i = stall ? (rnd[1:0] == 2'b00) : 1'b1;
        @(negedge clk_i);
        if (held) begin  // Offered word must wait unchanged
          check_bit("rd_valid_o", 1'b1, rd_valid_o);
          check_value("rd_data_o", held_data, rd_data_o);
        end
        hs        = rd_valid_o && rd_ready_i;
        held      = rd_valid_o && !rd_ready_i;
        held_data = rd_data_o;
        got       = rd_data_o;
        @(posedge clk_i);
        #1;
      end
      check_value("rd_data_o", exp, got);
      if (in_err_range(addr)) exp_err = 1'b1;
    end
    rd_ready_i = 1'b0;
    wait_done(exp_err);
  endtask

  ////////////////////
  // Directed tests

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk_i);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    check_bit("axi_awvalid_o", 1'b0, axi_awvalid_o);
    check_bit("axi_wvalid_o", 1'b0, axi_wvalid_o);
    check_bit("axi_arvalid_o", 1'b0, axi_arvalid_o);
    check_bit("rd_valid_o", 1'b0, rd_valid_o);
    check_bit("wr_ready_o", 1'b0, wr_ready_o);
    check_bit("done_o", 1'b0, done_o);
    check_bit("err_o", 1'b0, err_o);
    @(posedge clk_i);
    #1;
    finish_test("reset state", e0);
  endtask

  task automatic test_single_word();
    int e0;
    e0 = errors;
    do_write(32'h0000_0100, 13'd1, 1'b0);
    do_read(32'h0000_0100, 13'd1, 1'b0);
    finish_test("single word", e0);
  endtask

  task automatic test_write_burst();
    int e0;
    e0 = errors;
    do_write(32'h0000_0200, 13'd8, 1'b1);  // Host drops wr_valid_i at random
    do_read(32'h0000_0200, 13'd8, 1'b0);
    finish_test("write burst", e0);
  endtask

  task automatic test_read_backpressure();
    int e0;
    e0 = errors;
    do_write(32'h0000_0300, 13'd8, 1'b0);
    do_read(32'h0000_0300, 13'd8, 1'b1);
    finish_test("read backpressure", e0);
  endtask

  task automatic test_error_range();
    int e0;
    e0 = errors;
    // Two good words, then two in the faulting window
    do_write(32'hEFFF_FFF8, 13'd4, 1'b1);
    do_read(32'hEFFF_FFF8, 13'd4, 1'b1);
    finish_test("error range", e0);
  endtask

  task automatic test_zero_beats();
    int e0;
    e0 = errors;
    do_write(32'h0000_03E0, 13'd0, 1'b0);
    do_read(32'h0000_03E0, 13'd0, 1'b0);
    finish_test("zero beats", e0);
  endtask

  initial begin
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_beats_i = '0;
    wr_valid_i  = 1'b0;
    wr_data_i   = '0;
    rd_ready_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    test_reset_state();
    test_single_word();
    test_write_burst();
    test_read_backpressure();
    test_error_range();
    test_zero_beats();
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_run, checks,
             errors, dbg_mam_top_inst.dbg_mam_chk_inst.fails);
    if (errors == 0 && dbg_mam_top_inst.dbg_mam_chk_inst.fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/dbg_mam_pkg.sv */
`default_nettype none

package dbg_mam_pkg;

  ////////////////////
  // Bus geometry

  localparam int DATA_W     = 32;          // One bus word
  localparam int ADDR_W     = 32;          // Byte address
  localparam int STRB_W     = DATA_W / 8;  // Write strobes, always all set
  localparam int BEAT_W     = 13;          // Words per debug request
  localparam int WORD_BYTES = DATA_W / 8;  // Address step between beats

  ////////////////////
  // AXI response codes

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;  // Returned by the slave on a bad access

endpackage

`default_nettype wire

/* verilog/dbg_mam_top.sv */
`default_nettype none

module dbg_mam_top
  import dbg_mam_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  // Debug request
  input  wire               req_valid_i,
  output logic              req_ready_o,
  input  wire               req_we_i,
  input  wire  [ADDR_W-1:0] req_addr_i,
  input  wire  [BEAT_W-1:0] req_beats_i,
  // Host write words
  input  wire               wr_valid_i,
  input  wire  [DATA_W-1:0] wr_data_i,
  output logic              wr_ready_o,
  // Host read words
  output logic              rd_valid_o,
  output logic [DATA_W-1:0] rd_data_o,
  input  wire               rd_ready_i,
  // Completion
  output logic              done_o,
  output logic              err_o,
  // AXI4-Lite write side
  output logic [ADDR_W-1:0] axi_awaddr_o,
  output logic              axi_awvalid_o,
  input  wire               axi_awready_i,
  output logic [DATA_W-1:0] axi_wdata_o,
  output logic [STRB_W-1:0] axi_wstrb_o,
  output logic              axi_wvalid_o,
  input  wire               axi_wready_i,
  input  wire  [1:0]        axi_bresp_i,
  input  wire               axi_bvalid_i,
  output logic              axi_bready_o,
  // AXI4-Lite read side
  output logic [ADDR_W-1:0] axi_araddr_o,
  output logic              axi_arvalid_o,
  input  wire               axi_arready_i,
  input  wire  [DATA_W-1:0] axi_rdata_i,
  input  wire  [1:0]        axi_rresp_i,
  input  wire               axi_rvalid_i,
  output logic              axi_rready_o
);

  mam_cmd_if cmd_wr ();  // Controller to write engine
  mam_cmd_if cmd_rd ();  // Controller to read engine

  mam_req_ctrl mam_req_ctrl_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_beats_i (req_beats_i),
    .cmd_wr      (cmd_wr.ctrl),
    .cmd_rd      (cmd_rd.ctrl),
    .done_o      (done_o),
    .err_o       (err_o)
  );

  ////////////////////
  // Engines

  mam_write_engine mam_write_engine_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd           (cmd_wr.engine),
    .wr_valid_i    (wr_valid_i),
    .wr_data_i     (wr_data_i),
    .wr_ready_o    (wr_ready_o),
    .axi_awaddr_o  (axi_awaddr_o),
    .axi_awvalid_o (axi_awvalid_o),
    .axi_awready_i (axi_awready_i),
    .axi_wdata_o   (axi_wdata_o),
    .axi_wstrb_o   (axi_wstrb_o),
    .axi_wvalid_o  (axi_wvalid_o),
    .axi_wready_i  (axi_wready_i),
    .axi_bresp_i   (axi_bresp_i),
    .axi_bvalid_i  (axi_bvalid_i),
    .axi_bready_o  (axi_bready_o)
  );

  mam_read_engine mam_read_engine_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd           (cmd_rd.engine),
    .axi_araddr_o  (axi_araddr_o),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_arready_i (axi_arready_i),
    .axi_rdata_i   (axi_rdata_i),
    .axi_rresp_i   (axi_rresp_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_rready_o  (axi_rready_o),
    .rd_valid_o    (rd_valid_o),
    .rd_data_o     (rd_data_o),
    .rd_ready_i    (rd_ready_i)
  );

endmodule

`default_nettype wire

/* verilog/mam_cmd_if.sv */
`default_nettype none

// Command and completion link between the request controller and one engine
interface mam_cmd_if
  import dbg_mam_pkg::*;
();

  logic              cmd_valid;  // Controller offers a command
  logic              cmd_ready;  // Engine is idle
  logic [ADDR_W-1:0] cmd_addr;   // Base byte address
  logic [BEAT_W-1:0] cmd_beats;  // Word count, zero runs as one
  logic              done;       // One cycle pulse after the last beat
  logic              err;        // Any non-OKAY response, valid with done

  // Request side
  modport ctrl (
    output cmd_valid,
    output cmd_addr,
    output cmd_beats,
    input  cmd_ready,
    input  done,
    input  err
  );

  // Bus side
  modport engine (
    input  cmd_valid,
    input  cmd_addr,
    input  cmd_beats,
    output cmd_ready,
    output done,
    output err
  );

endinterface

`default_nettype wire

/* verilog/mam_read_engine.sv */
`default_nettype none

module mam_read_engine
  import dbg_mam_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  mam_cmd_if.engine         cmd,
  output logic [ADDR_W-1:0] axi_araddr_o,
  output logic              axi_arvalid_o,
  input  wire               axi_arready_i,
  input  wire  [DATA_W-1:0] axi_rdata_i,
  input  wire  [1:0]        axi_rresp_i,
  input  wire               axi_rvalid_i,
  output logic              axi_rready_o,
  output logic              rd_valid_o,
  output logic [DATA_W-1:0] rd_data_o,
  input  wire               rd_ready_i
);

  enum logic [1:0] {
    RD_IDLE,  // Waiting for a command
    RD_BUS,   // AR in flight, then the R beat
    RD_HOLD   // Word offered to the host
  } state_q;

  logic [BEAT_W-1:0] left_q;     // Words still to read after this one
  logic              err_q;      // Sticky over the whole request
  logic              done_q;
  logic              cmd_take;
  logic              r_take;     // R beat captured
  logic              host_take;  // Host took the held word
  logic              bad_resp;

  assign cmd_take  = cmd.cmd_valid & cmd.cmd_ready;
  assign r_take    = (state_q == RD_BUS) & axi_rvalid_i;
  assign host_take = rd_valid_o & rd_ready_i;
  assign bad_resp  = (axi_rresp_i != RESP_OKAY);

  assign cmd.cmd_ready = (state_q == RD_IDLE);
  assign cmd.done      = done_q;
  assign cmd.err       = err_q;

  assign axi_rready_o = 1'b1;                 // Only one read is ever outstanding
  assign rd_valid_o   = (state_q == RD_HOLD);  // Rises the cycle after rvalid

  ////////////////////
  // Beat sequencing

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= RD_IDLE;
      axi_arvalid_o <= 1'b0;
      done_q        <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        RD_IDLE: begin
          if (cmd_take) begin
            state_q       <= RD_BUS;
            axi_arvalid_o <= 1'b1;
            err_q         <= 1'b0;
          end
        end
        RD_BUS: begin
          if (axi_arready_i) begin
            axi_arvalid_o <= 1'b0;
          end
          if (axi_rvalid_i) begin
            state_q <= RD_HOLD;
            err_q   <= err_q | bad_resp;
          end
        end
        RD_HOLD: begin
          // Host back-pressure stalls the bus here
          if (rd_ready_i) begin
            state_q       <= (left_q == '0) ? RD_IDLE : RD_BUS;
            axi_arvalid_o <= (left_q != '0);  // Next read after the word is taken
            done_q        <= (left_q == '0);
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  ////////////////////
  // Address, count and data

  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      axi_araddr_o <= cmd.cmd_addr;
      left_q       <= (cmd.cmd_beats == '0) ? '0 : cmd.cmd_beats - 1'b1;
    end else if (host_take && left_q != '0) begin
      axi_araddr_o <= axi_araddr_o + ADDR_W'(WORD_BYTES);
      left_q       <= left_q - 1'b1;
    end
    if (r_take) begin
      rd_data_o <= axi_rdata_i;  // Stable for the whole hold
    end
  end

endmodule

`default_nettype wire

/* verilog/mam_req_ctrl.sv */
`default_nettype none

module mam_req_ctrl
  import dbg_mam_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               req_valid_i,
  output logic              req_ready_o,
  input  wire               req_we_i,
  input  wire  [ADDR_W-1:0] req_addr_i,
  input  wire  [BEAT_W-1:0] req_beats_i,
  mam_cmd_if.ctrl           cmd_wr,
  mam_cmd_if.ctrl           cmd_rd,
  output logic              done_o,
  output logic              err_o
);

  enum logic [1:0] {
    ST_IDLE,   // Open for a host request
    ST_ISSUE,  // Command offered to one engine
    ST_BUSY    // Engine running, wait for its done
  } state_q;

  logic              we_q;      // 1 routes to the write engine
  logic [ADDR_W-1:0] addr_q;
  logic [BEAT_W-1:0] beats_q;
  logic              issue;
  logic              cmd_fire;  // Chosen engine took the command
  logic              eng_done;
  logic              eng_err;

  assign req_ready_o = (state_q == ST_IDLE);
  assign issue       = (state_q == ST_ISSUE);

  ////////////////////
  // Command routing

  assign cmd_wr.cmd_valid = issue & we_q;
  assign cmd_rd.cmd_valid = issue & ~we_q;
  assign cmd_wr.cmd_addr  = addr_q;   // Both engines see the same payload
  assign cmd_rd.cmd_addr  = addr_q;
  assign cmd_wr.cmd_beats = beats_q;
  assign cmd_rd.cmd_beats = beats_q;

  assign cmd_fire = we_q ? (cmd_wr.cmd_valid & cmd_wr.cmd_ready)
                         : (cmd_rd.cmd_valid & cmd_rd.cmd_ready);

  // Only one engine runs at a time, so the two results can be merged
  assign eng_done = cmd_wr.done | cmd_rd.done;
  assign eng_err  = (cmd_wr.done & cmd_wr.err) | (cmd_rd.done & cmd_rd.err);

  ////////////////////
  // FSM and status

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;  // Status is a single pulse
      err_o  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_valid_i) begin
            state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (cmd_fire) begin
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (eng_done) begin
            state_q <= ST_IDLE;  // Back to idle while done_o is high
            done_o  <= 1'b1;
            err_o   <= eng_err;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_we_i;
      addr_q  <= req_addr_i;
      beats_q <= req_beats_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/mam_write_engine.sv */
`default_nettype none

module mam_write_engine
  import dbg_mam_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  mam_cmd_if.engine         cmd,
  input  wire               wr_valid_i,
  input  wire  [DATA_W-1:0] wr_data_i,
  output logic              wr_ready_o,
  output logic [ADDR_W-1:0] axi_awaddr_o,
  output logic              axi_awvalid_o,
  input  wire               axi_awready_i,
  output logic [DATA_W-1:0] axi_wdata_o,
  output logic [STRB_W-1:0] axi_wstrb_o,
  output logic              axi_wvalid_o,
  input  wire               axi_wready_i,
  input  wire  [1:0]        axi_bresp_i,
  input  wire               axi_bvalid_i,
  output logic              axi_bready_o
);

  enum logic [1:0] {
    WR_IDLE,  // Waiting for a command
    WR_DATA,  // Waiting for a host word
    WR_BEAT   // AW and W in flight, then the B response
  } state_q;

  logic [BEAT_W-1:0] left_q;    // Beats still to go after the current one
  logic              err_q;     // Sticky over the whole request
  logic              done_q;
  logic              cmd_take;
  logic              word_take;
  logic              beat_end;
  logic              bad_resp;

  assign cmd_take  = cmd.cmd_valid & cmd.cmd_ready;
  assign word_take = wr_valid_i & wr_ready_o;
  assign beat_end  = (state_q == WR_BEAT) & axi_bvalid_i;
  assign bad_resp  = (axi_bresp_i != RESP_OKAY);

  assign cmd.cmd_ready = (state_q == WR_IDLE);
  assign cmd.done      = done_q;
  assign cmd.err       = err_q;

  assign wr_ready_o   = (state_q == WR_DATA);
  assign axi_wstrb_o  = '1;    // Full word writes only
  assign axi_bready_o = 1'b1;  // B channel never stalls

  ////////////////////
  // Beat sequencing

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= WR_IDLE;
      axi_awvalid_o <= 1'b0;
      axi_wvalid_o  <= 1'b0;
      done_q        <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        WR_IDLE: begin
          if (cmd_take) begin
            state_q <= WR_DATA;
            err_q   <= 1'b0;  // Fresh request
          end
        end
        WR_DATA: begin
          if (word_take) begin
            state_q       <= WR_BEAT;
            axi_awvalid_o <= 1'b1;  // Both channels rise together
            axi_wvalid_o  <= 1'b1;
          end
        end
        WR_BEAT: begin
          // Each channel drops on its own after its handshake
          if (axi_awready_i) begin
            axi_awvalid_o <= 1'b0;
          end
          if (axi_wready_i) begin
            axi_wvalid_o <= 1'b0;
          end
          if (axi_bvalid_i) begin
            err_q   <= err_q | bad_resp;
            state_q <= (left_q == '0) ? WR_IDLE : WR_DATA;
            done_q  <= (left_q == '0);
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  ////////////////////
  // Address, count and data

  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      axi_awaddr_o <= cmd.cmd_addr;
      left_q       <= (cmd.cmd_beats == '0) ? '0 : cmd.cmd_beats - 1'b1;  // Zero runs as one
    end else if (beat_end && left_q != '0) begin
      axi_awaddr_o <= axi_awaddr_o + ADDR_W'(WORD_BYTES);
      left_q       <= left_q - 1'b1;
    end
    if (word_take) begin
      axi_wdata_o <= wr_data_i;  // Held until the next host word
    end
  end

endmodule

`default_nettype wire
